// File: files.f
+incdir+sim
hw/icache_geom_pkg.sv
hw/icache_fill_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_lru.sv
hw/icache.sv
sim/icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f files.f --top-module icache_tb \
  --Mdir obj_dir -o icache_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/icache_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

// File: sim/icache_tb_tasks.svh
/*
  Testbench tasks of the instruction cache
  - typed compare tasks
  - reference model helpers
  - fill packet and lookup drivers
  - directed tests
*/

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    abort_run("flag mismatch");
  end
endtask

task automatic check_instr(input string name,
                           input logic [icache_geom_pkg::instr_width-1:0] got,
                           input logic [icache_geom_pkg::instr_width-1:0] exp);
  if (got !== exp) begin
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    abort_run("instruction mismatch");
  end
endtask

task automatic check_addr(input string name,
                          input logic [icache_geom_pkg::paddr_width-1:0] got,
                          input logic [icache_geom_pkg::paddr_width-1:0] exp);
  if (got !== exp) begin
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    abort_run("address mismatch");
  end
endtask

task automatic check_way(input string name,
                         input logic [icache_geom_pkg::way_width-1:0] got,
                         input logic [icache_geom_pkg::way_width-1:0] exp);
  if (got !== exp) begin
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    abort_run("way mismatch");
  end
endtask

// lowest invalid way first or else the tree way by root then leaf
function automatic logic [1:0] victim_of(input int idx);
  logic [2:0] t;
  t = m_lru[idx];
  for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
    if (!m_valid[idx][w]) begin
      return 2'(w);
    end
  end
  return {t[0], t[0] ? t[2] : t[1]};
endfunction

task automatic lru_touch(input int idx, input logic [1:0] way);
  m_lru[idx][0] = ~way[1];
  if (way[1]) begin
    m_lru[idx][2] = ~way[0];
  end else begin
    m_lru[idx][1] = ~way[0];
  end
endtask

task automatic find_way(input int idx, input logic [20:0] tag,
                        output logic found, output logic [1:0] way);
  found = 1'b0;
  way   = '0;
  for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
    if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
      found = 1'b1;
      way   = 2'(w);
    end
  end
endtask

function automatic logic [31:0] make_paddr(input logic [20:0] tag, input int idx, input int word);
  return {tag, 6'(idx), 5'(word * 4)};
endfunction

// virtual page number unlike the physical one with the same page offset
function automatic logic [31:0] to_vaddr(input logic [31:0] pa);
  return {pa[31:12] ^ 20'hc3a5f, pa[11:0]};
endfunction

task automatic send_tag_pkt(input icache_fill_pkg::tag_op_e op, input int idx,
                            input int way, input logic [20:0] tag);
  @(posedge clk_i);
  tag_pkt_v_i     <= 1'b1;
  tag_pkt_op_i    <= op;
  tag_pkt_index_i <= 6'(idx);
  tag_pkt_way_i   <= 2'(way);
  tag_pkt_state_i <= icache_geom_pkg::coh_shared;
  tag_pkt_tag_i   <= tag;
  @(negedge clk_i);
  check_flag("tag_pkt_yumi_o", tag_pkt_yumi_o, 1'b1);
  @(posedge clk_i);
  tag_pkt_v_i <= 1'b0;
  case (op)
    icache_fill_pkg::tag_set_clear: begin
      for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
        m_valid[idx][w] = 1'b0;
        m_tag[idx][w]   = '0;
      end
    end
    icache_fill_pkg::tag_invalidate: m_valid[idx][way] = 1'b0;
    default: begin
      m_valid[idx][way] = 1'b1;
      m_tag[idx][way]   = tag;
    end
  endcase
endtask

function automatic logic [255:0] random_block();
  logic [255:0] blk;
  for (int i = 0; i < 8; i++) begin
    blk[i*32 +: 32] = $random(seed);
  end
  return blk;
endfunction

task automatic send_block(input int idx, input int way);
  logic [255:0] blk;
  blk = random_block();
  @(posedge clk_i);
  data_pkt_v_i     <= 1'b1;
  data_pkt_index_i <= 6'(idx);
  data_pkt_way_i   <= 2'(way);
  data_pkt_data_i  <= blk;
  @(negedge clk_i);
  check_flag("data_pkt_yumi_o", data_pkt_yumi_o, 1'b1);
  @(posedge clk_i);
  data_pkt_v_i <= 1'b0;
  m_block[idx][way] = blk;
endtask

// back-to-back lookups of addr_q that all should hit
task automatic lookup_hits();
  logic [31:0] pa;
  logic [1:0]  way;
  logic        found;
  int          idx;
  int          n;
  n = addr_q.size();
  for (int i = 0; i < n + 2; i++) begin
    @(posedge clk_i);
    if (i < n) begin
      vaddr_i   <= to_vaddr(addr_q[i]);
      vaddr_v_i <= 1'b1;
    end else begin
      vaddr_v_i <= 1'b0;
    end
    if (i >= 1 && i <= n) begin
      ptag_i   <= addr_q[i-1][31:12];
      ptag_v_i <= 1'b1;
    end else begin
      ptag_v_i <= 1'b0;
    end
    @(negedge clk_i);
    if (i >= 2) begin
      pa  = addr_q[i-2];
      idx = int'(pa[10:5]);
      find_way(idx, pa[31:11], found, way);
      if (!found) begin
        abort_run("reference model has no block for a lookup meant to hit");
      end
      check_flag("data_v_o", data_v_o, 1'b1);
      check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
      check_instr("data_o", data_o, m_block[idx][way][int'(pa[4:2])*32 +: 32]);
      lru_touch(idx, way);
    end
  end
  addr_q.delete();
endtask

task automatic lookup_miss(input logic [31:0] pa, input logic [1:0] exp_way);
  @(posedge clk_i);
  vaddr_i   <= to_vaddr(pa);
  vaddr_v_i <= 1'b1;
  @(posedge clk_i);
  vaddr_v_i <= 1'b0;
  ptag_i    <= pa[31:12];
  ptag_v_i  <= 1'b1;
  @(posedge clk_i);
  ptag_v_i <= 1'b0;
  @(negedge clk_i);
  check_flag("cache_req_v_o", cache_req_v_o, 1'b1);
  check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
  check_flag("data_v_o", data_v_o, 1'b0);
  check_addr("cache_req_addr_o", cache_req_addr_o, pa);
  @(negedge clk_i);
  check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b1);
  check_way("cache_req_way_o", cache_req_way_o, exp_way);
  // tracker holds until the fill side completes
  repeat (3) begin
    check_flag("miss_o", miss_o, 1'b1);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
    @(negedge clk_i);
  end
  @(posedge clk_i);
  cache_req_complete_i <= 1'b1;
  @(posedge clk_i);
  cache_req_complete_i <= 1'b0;
  @(negedge clk_i);
  check_flag("miss_o", miss_o, 1'b0);
  check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
endtask

task automatic test_reset_state();
  @(negedge clk_i);
  check_flag("data_v_o", data_v_o, 1'b0);
  check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
  check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
  check_flag("miss_o", miss_o, 1'b0);
  check_flag("tag_pkt_yumi_o", tag_pkt_yumi_o, 1'b0);
  check_flag("data_pkt_yumi_o", data_pkt_yumi_o, 1'b0);
  check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
endtask

task automatic test_cold_miss();
  send_tag_pkt(icache_fill_pkg::tag_set_clear, 3, 0, '0);
  lookup_miss(make_paddr(21'h0a5c3, 3, 5), victim_of(3));
endtask

task automatic test_hit_words();
  send_tag_pkt(icache_fill_pkg::tag_set_clear, 5, 0, '0);
  send_tag_pkt(icache_fill_pkg::tag_set_tag, 5, 2, 21'h13579);
  send_block(5, 2);
  for (int w = 0; w < 8; w++) begin
    addr_q.push_back(make_paddr(21'h13579, 5, w));
  end
  lookup_hits();
endtask

task automatic test_plru_victim();
  int order [4] = '{2, 0, 3, 1};
  send_tag_pkt(icache_fill_pkg::tag_set_clear, 9, 0, '0);
  for (int w = 0; w < 4; w++) begin
    send_tag_pkt(icache_fill_pkg::tag_set_tag, 9, w, 21'h00400 + 21'(w));
    send_block(9, w);
  end
  for (int i = 0; i < 4; i++) begin
    addr_q.push_back(make_paddr(21'h00400 + 21'(order[i]), 9, i * 2 + 1));
  end
  lookup_hits();
  lookup_miss(make_paddr(21'h1ffff, 9, 0), victim_of(9));
endtask

task automatic test_invalidate_victim();
  send_tag_pkt(icache_fill_pkg::tag_invalidate, 9, 1, '0);
  lookup_miss(make_paddr(21'h0beef, 9, 2), victim_of(9));
  send_tag_pkt(icache_fill_pkg::tag_set_clear, 9, 0, '0);
  lookup_miss(make_paddr(21'h0beef, 9, 2), victim_of(9));
endtask

task automatic test_fill_arbitration();
  logic [255:0] blk;
  @(posedge clk_i);
  cache_req_ready_i <= 1'b0;
  @(negedge clk_i);
  check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
  send_block(5, 2);
  @(posedge clk_i);
  cache_req_ready_i <= 1'b1;
  // lookups without ptag drop in TL yet still hold the packet off
  blk = random_block();
  @(posedge clk_i);
  vaddr_i          <= to_vaddr(make_paddr(21'h13579, 5, 0));
  vaddr_v_i        <= 1'b1;
  data_pkt_v_i     <= 1'b1;
  data_pkt_index_i <= 6'd5;
  data_pkt_way_i   <= 2'd2;
  data_pkt_data_i  <= blk;
  repeat (4) begin
    @(negedge clk_i);
    check_flag("data_pkt_yumi_o", data_pkt_yumi_o, 1'b0);
  end
  @(posedge clk_i);
  vaddr_v_i <= 1'b0;
  @(negedge clk_i);
  check_flag("data_pkt_yumi_o", data_pkt_yumi_o, 1'b1);
  @(posedge clk_i);
  data_pkt_v_i <= 1'b0;
  m_block[5][2] = blk;
  for (int w = 0; w < 8; w++) begin
    addr_q.push_back(make_paddr(21'h13579, 5, 7 - w));
  end
  lookup_hits();
endtask

// File: sim/icache_tb.sv
/*
  Instruction cache testbench top
  - clock, reset and DUT instance
  - watchdog
  - reference model of tags, blocks and pseudo-LRU bits
  - directed test sequence
*/
`timescale 1ns/1ps

module icache_tb;

  localparam int clk_period    = 20;
  localparam int reset_cycles  = 16;
  // rough sum of the directed test lengths
  localparam int test_cycles   = 260;
  localparam int margin_cycles = 140;

  logic                                          clk_i;
  logic                                          reset_i;
  logic [icache_geom_pkg::vaddr_width-1:0]       vaddr_i;
  logic                                          vaddr_v_i;
  logic                                          vaddr_ready_o;
  logic [icache_geom_pkg::ptag_width-1:0]        ptag_i;
  logic                                          ptag_v_i;
  logic [icache_geom_pkg::instr_width-1:0]       data_o;
  logic                                          data_v_o;
  logic                                          miss_o;
  logic [icache_fill_pkg::req_addr_width-1:0]    cache_req_addr_o;
  logic                                          cache_req_v_o;
  logic                                          cache_req_ready_i;
  logic [icache_fill_pkg::req_way_width-1:0]     cache_req_way_o;
  logic                                          cache_req_metadata_v_o;
  logic                                          cache_req_complete_i;
  logic                                          tag_pkt_v_i;
  icache_fill_pkg::tag_op_e                      tag_pkt_op_i;
  logic [icache_fill_pkg::fill_index_width-1:0]  tag_pkt_index_i;
  logic [icache_fill_pkg::fill_way_width-1:0]    tag_pkt_way_i;
  icache_geom_pkg::coh_state_e                   tag_pkt_state_i;
  logic [icache_fill_pkg::fill_tag_width-1:0]    tag_pkt_tag_i;
  logic                                          tag_pkt_yumi_o;
  logic                                          data_pkt_v_i;
  logic [icache_fill_pkg::fill_index_width-1:0]  data_pkt_index_i;
  logic [icache_fill_pkg::fill_way_width-1:0]    data_pkt_way_i;
  logic [icache_fill_pkg::fill_data_width-1:0]   data_pkt_data_i;
  logic                                          data_pkt_yumi_o;

  // reference model
  logic [icache_geom_pkg::tag_width-1:0]   m_tag   [icache_geom_pkg::sets][icache_geom_pkg::assoc];
  logic                                    m_valid [icache_geom_pkg::sets][icache_geom_pkg::assoc];
  logic [icache_geom_pkg::block_width-1:0] m_block [icache_geom_pkg::sets][icache_geom_pkg::assoc];
  logic [icache_geom_pkg::lru_width-1:0]   m_lru   [icache_geom_pkg::sets];

  logic [icache_geom_pkg::paddr_width-1:0] addr_q [$];
  integer                                  seed;

  icache i_icache (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #(clk_period / 2) clk_i = ~clk_i;
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  `include "icache_tb_tasks.svh"

  initial begin
    repeat (reset_cycles + test_cycles + margin_cycles) @(posedge clk_i);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    seed                 = 92;
    reset_i              = 1'b1;
    vaddr_i              = '0;
    vaddr_v_i            = 1'b0;
    ptag_i               = '0;
    ptag_v_i             = 1'b0;
    cache_req_ready_i    = 1'b1;
    cache_req_complete_i = 1'b0;
    tag_pkt_v_i          = 1'b0;
    tag_pkt_op_i         = icache_fill_pkg::tag_set_clear;
    tag_pkt_index_i      = '0;
    tag_pkt_way_i        = '0;
    tag_pkt_state_i      = icache_geom_pkg::coh_invalid;
    tag_pkt_tag_i        = '0;
    data_pkt_v_i         = 1'b0;
    data_pkt_index_i     = '0;
    data_pkt_way_i       = '0;
    data_pkt_data_i      = '0;
    for (int s = 0; s < icache_geom_pkg::sets; s++) begin
      m_lru[s] = '0;
      for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_block[s][w] = '0;
      end
    end
    repeat (reset_cycles) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_state();
    test_cold_miss();
    test_hit_words();
    test_plru_victim();
    test_invalidate_victim();
    test_fill_arbitration();

    $display("Regression passed");
    $finish;
  end

endmodule

// File: hw/icache.sv
/*
  Instruction cache top, virtually indexed and physically tagged
  - tag lookup (TL) and tag verify (TV) stage registers
  - miss request, delayed metadata and miss tracker
  - array sharing between lookups and fill packets
  - instruction select from the hit dword
*/
`timescale 1ns/1ps

module icache (
  input  logic                                        clk_i,
  input  logic                                        reset_i,

  // fetch port
  input  logic [icache_geom_pkg::vaddr_width-1:0]     vaddr_i,
  input  logic                                        vaddr_v_i,
  output logic                                        vaddr_ready_o,
  input  logic [icache_geom_pkg::ptag_width-1:0]      ptag_i,
  input  logic                                        ptag_v_i,
  output logic [icache_geom_pkg::instr_width-1:0]     data_o,
  output logic                                        data_v_o,
  output logic                                        miss_o,

  // miss request port
  output logic [icache_fill_pkg::req_addr_width-1:0]  cache_req_addr_o,
  output logic                                        cache_req_v_o,
  input  logic                                        cache_req_ready_i,
  output logic [icache_fill_pkg::req_way_width-1:0]   cache_req_way_o,
  output logic                                        cache_req_metadata_v_o,
  input  logic                                        cache_req_complete_i,

  // tag packets
  input  logic                                        tag_pkt_v_i,
  input  icache_fill_pkg::tag_op_e                    tag_pkt_op_i,
  input  logic [icache_fill_pkg::fill_index_width-1:0] tag_pkt_index_i,
  input  logic [icache_fill_pkg::fill_way_width-1:0]  tag_pkt_way_i,
  input  icache_geom_pkg::coh_state_e                 tag_pkt_state_i,
  input  logic [icache_fill_pkg::fill_tag_width-1:0]  tag_pkt_tag_i,
  output logic                                        tag_pkt_yumi_o,

  // data packets
  input  logic                                        data_pkt_v_i,
  input  logic [icache_fill_pkg::fill_index_width-1:0] data_pkt_index_i,
  input  logic [icache_fill_pkg::fill_way_width-1:0]  data_pkt_way_i,
  input  logic [icache_fill_pkg::fill_data_width-1:0] data_pkt_data_i,
  output logic                                        data_pkt_yumi_o
);

  logic                                          tl_we;
  logic                                          tv_we;
  logic [icache_geom_pkg::index_width-1:0]       vaddr_index;
  logic [icache_geom_pkg::bank_offset_width-1:0] vaddr_bank_offset;

  logic                                          v_tl_r;
  logic [icache_geom_pkg::page_offset_width-1:0] page_offset_tl_r;
  logic [icache_geom_pkg::paddr_width-1:0]       addr_tl;
  logic [icache_geom_pkg::assoc-1:0]             hit_tl;
  logic [icache_geom_pkg::assoc-1:0]             way_valid_tl;

  logic                                          v_tv_r;
  logic [icache_geom_pkg::paddr_width-1:0]       addr_tv_r;
  logic [icache_geom_pkg::assoc-1:0]             hit_tv_r;
  logic [icache_geom_pkg::assoc-1:0]             way_valid_tv_r;
  logic [icache_geom_pkg::index_width-1:0]       index_tv;
  logic                                          hit_tv;
  logic                                          miss_tv;
  logic [icache_geom_pkg::way_width-1:0]         hit_way_tv;
  logic [icache_geom_pkg::way_width-1:0]         victim_way;
  logic [icache_geom_pkg::bank_width-1:0]        dword_tv;

  logic                                          metadata_v_r;
  logic [icache_geom_pkg::way_width-1:0]         req_way_r;
  logic                                          miss_r;

  // lookups own the arrays, fill packets take idle cycles
  assign tl_we           = vaddr_v_i & cache_req_ready_i;
  assign tag_pkt_yumi_o  = tag_pkt_v_i & ~tl_we;
  assign data_pkt_yumi_o = data_pkt_v_i & ~tl_we;

  assign vaddr_index       = vaddr_i[icache_geom_pkg::index_lsb +: icache_geom_pkg::index_width];
  assign vaddr_bank_offset =
    vaddr_i[icache_geom_pkg::byte_offset_width +: icache_geom_pkg::bank_offset_width];

  // TL stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      page_offset_tl_r <= vaddr_i[icache_geom_pkg::page_offset_width-1:0];
    end
  end

  // ptag arrives one cycle behind the vaddr
  assign addr_tl = {ptag_i, page_offset_tl_r};

  icache_tag_array tag_array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_v_i     (tl_we),
    .rd_index_i (vaddr_index),
    .addr_tag_i (addr_tl[icache_geom_pkg::tag_lsb +: icache_geom_pkg::tag_width]),
    .wr_v_i     (tag_pkt_yumi_o),
    .wr_op_i    (tag_pkt_op_i),
    .wr_index_i (tag_pkt_index_i),
    .wr_way_i   (tag_pkt_way_i),
    .wr_state_i (tag_pkt_state_i),
    .wr_tag_i   (tag_pkt_tag_i),
    .hit_o      (hit_tl),
    .way_valid_o(way_valid_tl)
  );

  // TV stage, a lookup without ptag is dropped here
  assign tv_we = v_tl_r & ptag_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else begin
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      addr_tv_r      <= addr_tl;
      hit_tv_r       <= hit_tl;
      way_valid_tv_r <= way_valid_tl;
    end
  end

  assign index_tv = addr_tv_r[icache_geom_pkg::index_lsb +: icache_geom_pkg::index_width];
  assign hit_tv   = v_tv_r & (|hit_tv_r);
  assign miss_tv  = v_tv_r & ~(|hit_tv_r);

  always_comb begin
    hit_way_tv = '0;
    for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
      if (hit_tv_r[w]) begin
        hit_way_tv = hit_way_tv | icache_geom_pkg::way_width'(w);
      end
    end
  end

  icache_data_array data_array (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .rd_v_i           (tl_we),
    .rd_index_i       (vaddr_index),
    .rd_bank_offset_i (vaddr_bank_offset),
    .wr_v_i           (data_pkt_yumi_o),
    .wr_index_i       (data_pkt_index_i),
    .wr_way_i         (data_pkt_way_i),
    .wr_block_i       (data_pkt_data_i),
    .hit_way_i        (hit_tv_r),
    .sel_bank_offset_i(addr_tv_r[icache_geom_pkg::byte_offset_width +:
                                 icache_geom_pkg::bank_offset_width]),
    .dword_o          (dword_tv)
  );

  icache_lru lru (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_index_i  (index_tv),
    .upd_v_i     (hit_tv),
    .upd_index_i (index_tv),
    .upd_way_i   (hit_way_tv),
    .way_valid_i (way_valid_tv_r),
    .victim_way_o(victim_way)
  );

  assign data_v_o = hit_tv;
  assign data_o   = addr_tv_r[icache_geom_pkg::word_sel_bit]
                  ? dword_tv[icache_geom_pkg::instr_width +: icache_geom_pkg::instr_width]
                  : dword_tv[0 +: icache_geom_pkg::instr_width];

  // miss request, not held when the port is busy
  assign cache_req_v_o    = miss_tv & cache_req_ready_i;
  assign cache_req_addr_o = addr_tv_r;

  // victim captured with the request, next TV may belong to another lookup
  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) begin
      req_way_r <= victim_way;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      metadata_v_r <= 1'b0;
      miss_r       <= 1'b0;
    end else begin
      metadata_v_r <= cache_req_v_o;
      if (cache_req_v_o) begin
        miss_r <= 1'b1;
      end else if (cache_req_complete_i) begin
        miss_r <= 1'b0;
      end
    end
  end

  assign cache_req_way_o        = req_way_r;
  assign cache_req_metadata_v_o = metadata_v_r;
  assign miss_o                 = miss_r;
  assign vaddr_ready_o          = cache_req_ready_i & ~miss_r & ~cache_req_v_o;

  // one TV cycle either returns an instruction or asks for the block
  a_hit_or_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_o && cache_req_v_o));

endmodule

// File: hw/icache_lru.sv
/*
  Tree pseudo-LRU replacement state
  - three tree bits per set, cleared by reset
  - update toward the other half and way on a hit
  - victim choice, lowest invalid way first
*/
`timescale 1ns/1ps

module icache_lru (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [icache_geom_pkg::index_width-1:0] rd_index_i,
  input  logic                                    upd_v_i,
  input  logic [icache_geom_pkg::index_width-1:0] upd_index_i,
  input  logic [icache_geom_pkg::way_width-1:0]   upd_way_i,
  input  logic [icache_geom_pkg::assoc-1:0]       way_valid_i,
  output logic [icache_geom_pkg::way_width-1:0]   victim_way_o
);

  // bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
  logic [icache_geom_pkg::lru_width-1:0] tree_r [icache_geom_pkg::sets];
  logic [icache_geom_pkg::lru_width-1:0] tree;
  logic [icache_geom_pkg::way_width-1:0] tree_way;
  logic [icache_geom_pkg::way_width-1:0] invalid_way;
  logic                                  invalid_exist;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < icache_geom_pkg::sets; s++) begin
        tree_r[s] <= '0;
      end
    end else if (upd_v_i) begin
      // root away from the used half
      tree_r[upd_index_i][0] <= ~upd_way_i[1];
      if (upd_way_i[1]) begin
        tree_r[upd_index_i][2] <= ~upd_way_i[0];
      end else begin
        tree_r[upd_index_i][1] <= ~upd_way_i[0];
      end
    end
  end

  assign tree     = tree_r[rd_index_i];
  assign tree_way = {tree[0], tree[0] ? tree[2] : tree[1]};

  // scan from the top so the lowest invalid way wins
  always_comb begin
    invalid_exist = 1'b0;
    invalid_way   = '0;
    for (int w = icache_geom_pkg::assoc - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        invalid_exist = 1'b1;
        invalid_way   = icache_geom_pkg::way_width'(w);
      end
    end
  end

  assign victim_way_o = invalid_exist ? invalid_way : tree_way;

endmodule

// File: hw/icache_data_array.sv
/*
  Instruction data storage
  - four bank memories, one dword per entry
  - fill writes rotated by way, one entry per bank
  - read dword registers and hit-way bank select
*/
`timescale 1ns/1ps

module icache_data_array (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          rd_v_i,
  input  logic [icache_geom_pkg::index_width-1:0]       rd_index_i,
  input  logic [icache_geom_pkg::bank_offset_width-1:0] rd_bank_offset_i,
  input  logic                                          wr_v_i,
  input  logic [icache_geom_pkg::index_width-1:0]       wr_index_i,
  input  logic [icache_geom_pkg::way_width-1:0]         wr_way_i,
  input  logic [icache_geom_pkg::block_width-1:0]       wr_block_i,
  input  logic [icache_geom_pkg::assoc-1:0]             hit_way_i,
  input  logic [icache_geom_pkg::bank_offset_width-1:0] sel_bank_offset_i,
  output logic [icache_geom_pkg::bank_width-1:0]        dword_o
);

  logic [icache_geom_pkg::assoc-1:0][icache_geom_pkg::bank_width-1:0] bank_dword;
  logic                                          rd_v_r;
  logic [icache_geom_pkg::way_width-1:0]         hit_way;
  logic [icache_geom_pkg::bank_offset_width-1:0] sel_bank;

  // high in the cycle the bank outputs hold a fresh lookup read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= rd_v_i;
    end
  end

  // bank b keeps dword (b - way) mod 4 of each way's block
  for (genvar b = 0; b < icache_geom_pkg::assoc; b++) begin : g_bank
    logic [icache_geom_pkg::bank_width-1:0]        mem_r [icache_geom_pkg::sets *
                                                          icache_geom_pkg::assoc];
    logic [icache_geom_pkg::bank_width-1:0]        rd_r;
    logic [icache_geom_pkg::bank_width-1:0]        tv_r;
    logic [icache_geom_pkg::bank_offset_width-1:0] wr_offset;

    assign wr_offset = icache_geom_pkg::bank_offset_width'(b) - wr_way_i;

    always_ff @(posedge clk_i) begin
      if (wr_v_i) begin
        mem_r[{wr_index_i, wr_offset}] <=
          wr_block_i[wr_offset*icache_geom_pkg::bank_width +: icache_geom_pkg::bank_width];
      end else if (rd_v_i) begin
        rd_r <= mem_r[{rd_index_i, rd_bank_offset_i}];
      end
    end

    // held for the verify stage
    always_ff @(posedge clk_i) begin
      if (rd_v_r) begin
        tv_r <= rd_r;
      end
    end

    assign bank_dword[b] = tv_r;
  end

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
      if (hit_way_i[w]) begin
        hit_way = hit_way | icache_geom_pkg::way_width'(w);
      end
    end
  end

  // the wanted dword of the hit way sits in bank (way + offset) mod 4
  assign sel_bank = hit_way + sel_bank_offset_i;
  assign dword_o  = bank_dword[sel_bank];

endmodule

// File: hw/icache_tag_array.sv
/*
  Tag and coherence state storage of all ways
  - one synchronous memory, one set per word
  - set_clear, invalidate and set_tag writes
  - per-way hit and valid compare of the set read last cycle
*/
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     rd_v_i,
  input  logic [icache_geom_pkg::index_width-1:0]  rd_index_i,
  input  logic [icache_geom_pkg::tag_width-1:0]    addr_tag_i,
  input  logic                                     wr_v_i,
  input  icache_fill_pkg::tag_op_e                 wr_op_i,
  input  logic [icache_geom_pkg::index_width-1:0]  wr_index_i,
  input  logic [icache_geom_pkg::way_width-1:0]    wr_way_i,
  input  icache_geom_pkg::coh_state_e              wr_state_i,
  input  logic [icache_geom_pkg::tag_width-1:0]    wr_tag_i,
  output logic [icache_geom_pkg::assoc-1:0]        hit_o,
  output logic [icache_geom_pkg::assoc-1:0]        way_valid_o
);

  typedef struct packed {
    icache_geom_pkg::coh_state_e              state;
    logic [icache_geom_pkg::tag_width-1:0]    tag;
  } tag_entry_s;

  tag_entry_s [icache_geom_pkg::assoc-1:0] mem_r [icache_geom_pkg::sets];
  tag_entry_s [icache_geom_pkg::assoc-1:0] rd_data_r;
  logic                                    rd_v_r;

  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      for (int w = 0; w < icache_geom_pkg::assoc; w++) begin
        case (wr_op_i)
          icache_fill_pkg::tag_set_clear: begin
            mem_r[wr_index_i][w].state <= icache_geom_pkg::coh_invalid;
            mem_r[wr_index_i][w].tag   <= '0;
          end
          // tag bits of the way are left alone
          icache_fill_pkg::tag_invalidate: begin
            if (wr_way_i == icache_geom_pkg::way_width'(w)) begin
              mem_r[wr_index_i][w].state <= icache_geom_pkg::coh_invalid;
            end
          end
          icache_fill_pkg::tag_set_tag: begin
            if (wr_way_i == icache_geom_pkg::way_width'(w)) begin
              mem_r[wr_index_i][w].state <= wr_state_i;
              mem_r[wr_index_i][w].tag   <= wr_tag_i;
            end
          end
          default: begin
          end
        endcase
      end
    end else if (rd_v_i) begin
      rd_data_r <= mem_r[rd_index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= rd_v_i;
    end
  end

  // compare happens in the cycle after the read, once the ptag is known
  for (genvar w = 0; w < icache_geom_pkg::assoc; w++) begin : g_cmp
    assign way_valid_o[w] = (rd_data_r[w].state != icache_geom_pkg::coh_invalid);
    assign hit_o[w]       = way_valid_o[w] & (rd_data_r[w].tag == addr_tag_i);
  end

  // a block never sits in two ways of one set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_v_r |-> $onehot0(hit_o));

  // the top gives the array to either a lookup or a fill packet
  a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wr_v_i && rd_v_i));

endmodule

// File: hw/icache_fill_pkg.sv
/*
  Fill and request port definitions
  - tag packet opcodes
  - field widths of the tag, data and request ports
*/
package icache_fill_pkg;

  typedef enum logic [1:0] {
    tag_set_clear  = 2'd0,
    tag_invalidate = 2'd1,
    tag_set_tag    = 2'd2
  } tag_op_e;

  // fill packet fields
  localparam int fill_index_width = icache_geom_pkg::index_width;
  localparam int fill_way_width   = icache_geom_pkg::way_width;
  localparam int fill_tag_width   = icache_geom_pkg::tag_width;
  // one packet carries a whole block
  localparam int fill_data_width  = icache_geom_pkg::block_width;

  // miss request fields
  localparam int req_addr_width = icache_geom_pkg::paddr_width;
  localparam int req_way_width  = icache_geom_pkg::way_width;

endpackage

// File: hw/icache_geom_pkg.sv
/*
  Instruction cache geometry
  - address widths and field positions
  - set, way, bank and block sizes
  - coherence state encoding of a way
*/
package icache_geom_pkg;

  // address widths
  localparam int vaddr_width       = 32;
  localparam int paddr_width       = 32;
  localparam int page_offset_width = 12;
  localparam int ptag_width        = paddr_width - page_offset_width;

  // organisation
  localparam int sets        = 64;
  localparam int assoc       = 4;
  localparam int way_width   = 2;
  localparam int block_width = 256;
  localparam int bank_width  = 64;
  localparam int instr_width = 32;
  localparam int lru_width   = assoc - 1;

  // field positions in an address
  localparam int byte_offset_width = 3;
  localparam int bank_offset_width = 2;
  localparam int index_width       = 6;
  localparam int index_lsb         = byte_offset_width + bank_offset_width;
  localparam int tag_lsb           = index_lsb + index_width;
  localparam int tag_width         = paddr_width - tag_lsb;
  // picks the upper or lower instruction of a dword
  localparam int word_sel_bit      = 2;

  typedef enum logic [1:0] {
    coh_invalid   = 2'd0,
    coh_shared    = 2'd1,
    coh_exclusive = 2'd2
  } coh_state_e;

endpackage
